// ==== flist.f ====
+incdir+testbench
verilog/noc_pkg.sv
verilog/input_queue.sv
verilog/route_calc.sv
verilog/output_stage.sv
verilog/noc_router.sv
testbench/tb_router.sv

// ==== run.sh ====
#!/bin/sh
# Build and run the router testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary -Wno-fatal --top-module tb_router -f flist.f -o tb_router

./obj_dir/tb_router > sim.log
cat sim.log

if grep -q "Result: FAILED" sim.log; then
  echo "Simulation reported failure"
  exit 1
fi
if ! grep -q "Result: PASSED" sim.log; then
  echo "Simulation ended without a result"
  exit 1
fi
exit 0

// ==== testbench/tb_checks.svh ====
`ifndef TB_CHECKS_SVH
`define TB_CHECKS_SVH

// ----------------------------------------
// Counters and scoreboard
// ----------------------------------------
int error_count = 0;  // Mismatches plus timeouts
int test_count  = 0;  // Finished tests

// Expected packets, one queue per output and source pair
noc_pkg::packet_t exp_q [noc_pkg::N_PORTS * noc_pkg::N_PORTS][$];
int core_srcs [$];    // Source of each packet seen on the core output

task automatic check_packet(input noc_pkg::packet_t got, input noc_pkg::packet_t exp,
                            input string msg);
  if (got !== exp) begin
    $display("ERROR at %0t: %0s, got %h expected %h", $time, msg, got, exp);
    error_count++;
  end
endtask

task automatic check_ports(input noc_pkg::port_vec_t got, input noc_pkg::port_vec_t exp,
                           input string msg);
  if (got !== exp) begin
    $display("ERROR at %0t: %0s, got %b expected %b", $time, msg, got, exp);
    error_count++;
  end
endtask

// Packet counts and port numbers
task automatic check_count(input int got, input int exp, input string msg);
  if (got != exp) begin
    $display("ERROR at %0t: %0s, got %0d expected %0d", $time, msg, got, exp);
    error_count++;
  end
endtask

task automatic expect_packet(input int src, input int out, input noc_pkg::packet_t pkt);
  exp_q[out * noc_pkg::N_PORTS + src].push_back(pkt);  // Kept in send order
endtask

function automatic int pending_count();
  int total = 0;
  for (int i = 0; i < noc_pkg::N_PORTS * noc_pkg::N_PORTS; i++) begin
    total += exp_q[i].size();
  end
  return total;
endfunction

// Match one delivered packet against the oldest one expected from its source
task automatic record_output(input int out, input noc_pkg::packet_t pkt);
  int src;
  src = int'(pkt.payload[noc_pkg::PAYLOAD_W-1 -: 4]);  // Source in top nibble
  if (src >= noc_pkg::N_PORTS || exp_q[out * noc_pkg::N_PORTS + src].size() == 0) begin
    $display("ERROR at %0t: unexpected packet %h on output %0d", $time, pkt, out);
    error_count++;
  end else begin
    check_packet(pkt, exp_q[out * noc_pkg::N_PORTS + src].pop_front(),
                 $sformatf("packet on output %0d", out));
    if (out == noc_pkg::PORT_CORE) begin
      core_srcs.push_back(src);
    end
  end
endtask

task automatic finish_test(input string name, input int errs_before);
  test_count++;
  $display("Test %0s done, %0d errors", name, error_count - errs_before);
endtask

`endif

// ==== testbench/tb_router.sv ====
module tb_router;

  localparam noc_pkg::coord_t X_LOC = 2'd1;  // Router column
  localparam noc_pkg::coord_t Y_LOC = 2'd2;  // Router row

  logic                 clk = 1'b0;
  logic                 reset_n;
  noc_pkg::packet_bus_t i_data;
  noc_pkg::port_vec_t   i_data_val;
  noc_pkg::port_vec_t   o_en;
  noc_pkg::packet_bus_t o_data;
  noc_pkg::port_vec_t   o_data_val;
  noc_pkg::port_vec_t   i_en;

  int unsigned lcg_state = 32'd23989;  // LCG seed
  int          seq_num   = 0;          // Unique number per packet

  `include "tb_checks.svh"

  noc_router #(.X_LOC(X_LOC), .Y_LOC(Y_LOC)) uut (
    .clk(clk), .reset_n(reset_n), .i_data(i_data), .i_data_val(i_data_val), .o_en(o_en),
    .o_data(o_data), .o_data_val(o_data_val), .i_en(i_en)
  );

  always #20 clk = ~clk;  // Period 40

  function automatic logic [15:0] lcg_next();
    lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
    return lcg_state[30:15];
  endfunction

  // XY order with the column resolved first
  function automatic int xy_port(input noc_pkg::packet_t pkt);
    if (pkt.x_dest > X_LOC) return noc_pkg::PORT_EAST;
    if (pkt.x_dest < X_LOC) return noc_pkg::PORT_WEST;
    if (pkt.y_dest > Y_LOC) return noc_pkg::PORT_SOUTH;
    if (pkt.y_dest < Y_LOC) return noc_pkg::PORT_NORTH;
    return noc_pkg::PORT_CORE;
  endfunction

  function automatic noc_pkg::packet_t make_packet(input noc_pkg::coord_t x,
                                                   input noc_pkg::coord_t y, input int src);
    noc_pkg::packet_t pkt;
    pkt.x_dest  = x;
    pkt.y_dest  = y;
    pkt.payload = {4'(src), 12'(seq_num)};  // Source in the top nibble and sequence below
    seq_num++;
    return pkt;
  endfunction

  // Outputs are stable at the falling edge
  always @(negedge clk) begin
    if (reset_n) begin
      check_ports(o_data_val & ~i_en, '0, "valid on a blocked output");
      for (int q = 0; q < noc_pkg::N_PORTS; q++) begin
        if (o_data_val[q]) record_output(q, o_data[q]);
      end
    end
  end

  // ----------------------------------------
  // Driver tasks
  // ----------------------------------------
  task automatic send_packet(input int src, input noc_pkg::packet_t pkt, input int out);
    int waited = 0;
    while (!o_en[src] && waited < 50) begin  // Wait for room in the queue
      @(posedge clk);
      #2;
      waited++;
    end
    if (!o_en[src]) begin
      $display("Input %0d never signalled room for a packet", src);
      error_count++;
    end else begin
      i_data[src]     = pkt;
      i_data_val[src] = 1'b1;
      expect_packet(src, out, pkt);
      @(posedge clk);                        // Accepted here
      #2;
      i_data_val[src] = 1'b0;
    end
  endtask

  task automatic wait_drained(input string what);
    int waited = 0;
    while (pending_count() != 0 && waited < 200) begin
      @(posedge clk);
      #2;
      waited++;
    end
    if (pending_count() != 0) begin
      $display("In %0s, %0d packets never reached an output", what, pending_count());
      error_count++;
    end
  endtask

  // ----------------------------------------
  // Tests
  // ----------------------------------------
  task automatic test_reset();
    int errs = error_count;
    check_ports(o_data_val, '0, "o_data_val after reset");
    check_ports(o_en, '1, "o_en after reset");
    finish_test("reset", errs);
  endtask

  task automatic test_routing();
    int errs = error_count;
    send_packet(noc_pkg::PORT_CORE, make_packet(2'd2, 2'd0, 0), noc_pkg::PORT_EAST);
    send_packet(noc_pkg::PORT_CORE, make_packet(2'd0, 2'd3, 0), noc_pkg::PORT_WEST);
    send_packet(noc_pkg::PORT_CORE, make_packet(2'd1, 2'd3, 0), noc_pkg::PORT_SOUTH);
    send_packet(noc_pkg::PORT_CORE, make_packet(2'd1, 2'd0, 0), noc_pkg::PORT_NORTH);
    send_packet(noc_pkg::PORT_CORE, make_packet(X_LOC, Y_LOC, 0), noc_pkg::PORT_CORE);
    wait_drained("routing");
    finish_test("routing", errs);
  endtask

  task automatic test_backpressure();
    int errs     = error_count;
    int accepted = 0;
    logic taken;
    noc_pkg::packet_t pkt;
    i_en[noc_pkg::PORT_EAST] = 1'b0;
    pkt = make_packet(2'd3, 2'd1, noc_pkg::PORT_WEST);  // East-bound
    i_data[noc_pkg::PORT_WEST]     = pkt;
    i_data_val[noc_pkg::PORT_WEST] = 1'b1;               // Offered every cycle
    for (int c = 0; c < 60 && (c <= 12 || accepted < 6); c++) begin
      if (c == 12) begin                                 // Queue long since full
        check_count(accepted, noc_pkg::QUEUE_DEPTH, "packets taken with east blocked");
        i_en[noc_pkg::PORT_EAST] = 1'b1;
      end
      taken = o_en[noc_pkg::PORT_WEST];
      if (taken) expect_packet(noc_pkg::PORT_WEST, noc_pkg::PORT_EAST, pkt);
      @(posedge clk);
      #2;
      if (taken) begin
        accepted++;
        pkt = make_packet(2'd3, 2'd1, noc_pkg::PORT_WEST);
        i_data[noc_pkg::PORT_WEST] = pkt;
      end
    end
    i_data_val[noc_pkg::PORT_WEST] = 1'b0;
    if (accepted < 6) begin
      $display("West input took only %0d of 6 packets", accepted);
      error_count++;
    end
    wait_drained("back-pressure");
    finish_test("back-pressure", errs);
  endtask

  task automatic test_fairness();
    int errs = error_count;
    i_en[noc_pkg::PORT_CORE] = 1'b0;
    for (int n = 0; n < 3; n++) begin
      send_packet(noc_pkg::PORT_NORTH, make_packet(X_LOC, Y_LOC, 1), noc_pkg::PORT_CORE);
      send_packet(noc_pkg::PORT_SOUTH, make_packet(X_LOC, Y_LOC, 3), noc_pkg::PORT_CORE);
    end
    core_srcs.delete();
    i_en[noc_pkg::PORT_CORE] = 1'b1;
    wait_drained("fairness");
    check_count(core_srcs.size(), 6, "packets on core output");
    for (int n = 0; n < core_srcs.size(); n++) begin
      check_count(core_srcs[n], (n % 2 == 0) ? noc_pkg::PORT_NORTH : noc_pkg::PORT_SOUTH,
                  "core grant order");
    end
    finish_test("fairness", errs);
  endtask

  task automatic test_random();
    int errs   = error_count;
    int sent   = 0;
    int cycles = 0;
    logic [15:0] r;
    noc_pkg::packet_t pkt;
    while (sent < 200 && cycles < 3000) begin
      for (int p = 0; p < noc_pkg::N_PORTS; p++) begin
        r = lcg_next();
        i_en[p]       = (r[9:8] != 2'b00);   // Downstream ready 3 times in 4
        i_data_val[p] = 1'b0;
        if (r[0] && o_en[p] && sent < 200) begin
          pkt = make_packet(r[5:4], r[7:6], p);
          i_data[p]     = pkt;
          i_data_val[p] = 1'b1;
          expect_packet(p, xy_port(pkt), pkt);
          sent++;
        end
      end
      @(posedge clk);
      #2;
      cycles++;
    end
    i_data_val = '0;
    i_en       = '1;
    if (sent < 200) begin
      $display("Random traffic sent only %0d of 200 packets", sent);
      error_count++;
    end
    wait_drained("random traffic");
    finish_test("random", errs);
  endtask

  initial begin
    reset_n    = 1'b0;
    i_data     = '0;
    i_data_val = '0;
    i_en       = '1;
    repeat (2) @(posedge clk);
    #2;
    reset_n = 1'b1;
    test_reset();
    test_routing();
    test_backpressure();
    test_fairness();
    test_random();
    repeat (5) @(posedge clk);              // Catch any late extra packet
    $display("Tests run: %0d, errors: %0d", test_count, error_count);
    if (error_count == 0) begin
      $display("Result: PASSED");
    end else begin
      $display("Result: FAILED");
    end
    $finish;
  end

endmodule

// ==== verilog/noc_router.sv ====
module noc_router #(
  parameter noc_pkg::coord_t X_LOC = '0,  // Router column in the mesh
  parameter noc_pkg::coord_t Y_LOC = '0   // Router row in the mesh
) (
  input  logic                 clk,
  input  logic                 reset_n,

  // ----------------------------------------
  // Upstream side
  // ----------------------------------------
  input  noc_pkg::packet_bus_t i_data,      // Packets from upstream, core first
  input  noc_pkg::port_vec_t   i_data_val,  // Upstream valids
  output noc_pkg::port_vec_t   o_en,        // Queue has room, per input

  // ----------------------------------------
  // Downstream side
  // ----------------------------------------
  output noc_pkg::packet_bus_t o_data,      // Switched packets
  output noc_pkg::port_vec_t   o_data_val,  // Output carries a packet
  input  noc_pkg::port_vec_t   i_en         // Downstream can take a packet
);

  // Internal nets between the queues and the output stage
  noc_pkg::packet_bus_t l_heads;     // Head packet of each queue
  noc_pkg::port_vec_t   l_head_val;  // Head valid of each queue
  noc_pkg::req_mat_t    l_req;       // [input][output] requests
  noc_pkg::port_vec_t   l_rd;        // Pop strobes back to the queues

  // One queue and one route calculator per input port
  for (genvar i = 0; i < noc_pkg::N_PORTS; i++) begin : g_input
    input_queue u_queue (
      .clk        (clk),
      .reset_n    (reset_n),
      .i_data     (i_data[i]),      // Upstream packet
      .i_data_val (i_data_val[i]),
      .o_en       (o_en[i]),        // Back to upstream sender
      .i_rd       (l_rd[i]),        // From the output stage
      .o_head     (l_heads[i]),
      .o_head_val (l_head_val[i])
    );

    // Routes the packet waiting at the queue head
    route_calc #(
      .X_LOC (X_LOC),
      .Y_LOC (Y_LOC)
    ) u_route (
      .i_head     (l_heads[i]),
      .i_head_val (l_head_val[i]),
      .o_req      (l_req[i])        // One request row per input
    );
  end

  // Arbitration and switching, shared by all outputs
  output_stage u_output (
    .clk        (clk),
    .reset_n    (reset_n),
    .i_req      (l_req),
    .i_heads    (l_heads),
    .i_en       (i_en),             // Downstream back-pressure
    .o_rd       (l_rd),
    .o_data     (o_data),
    .o_data_val (o_data_val)
  );

endmodule

// ==== verilog/output_stage.sv ====
module output_stage (
  input  logic                 clk,
  input  logic                 reset_n,
  input  noc_pkg::req_mat_t    i_req,       // [input][output] from route calculators
  input  noc_pkg::packet_bus_t i_heads,     // Head packet of each input queue
  input  noc_pkg::port_vec_t   i_en,        // Downstream enables, one per output
  output noc_pkg::port_vec_t   o_rd,        // Pop strobe per input queue
  output noc_pkg::packet_bus_t o_data,      // Switched packets, one per output
  output noc_pkg::port_vec_t   o_data_val   // Output carries a packet this cycle
);

  // ----------------------------------------
  // Arbitration state
  // ----------------------------------------
  noc_pkg::port_idx_t rr_ptr  [noc_pkg::N_PORTS];  // Round-robin start, per output
  noc_pkg::port_idx_t gnt_idx [noc_pkg::N_PORTS];  // Encoded winner, per output
  noc_pkg::req_mat_t  grant;                       // [output][input], one-hot rows

  // Pointer position just past a winner
  function automatic noc_pkg::port_idx_t idx_inc(input noc_pkg::port_idx_t idx);
    if (idx == noc_pkg::port_idx_t'(noc_pkg::N_PORTS - 1)) begin
      return noc_pkg::port_idx_t'(noc_pkg::PORT_CORE);
    end
    return idx + 1'b1;
  endfunction

  // Per-output arbiter
  // Scan inputs cyclically from the pointer, first requester wins
  always_comb begin
    int idx;
    for (int q = 0; q < noc_pkg::N_PORTS; q++) begin
      grant[q]   = '0;
      gnt_idx[q] = '0;
      for (int k = 0; k < noc_pkg::N_PORTS; k++) begin
        idx = int'(rr_ptr[q]) + k;
        if (idx >= noc_pkg::N_PORTS) begin
          idx = idx - noc_pkg::N_PORTS;    // Wrap back towards core
        end
        // Blocked output grants nothing, the head just waits
        if (!(|grant[q]) && i_req[idx][q] && i_en[q]) begin
          grant[q][idx] = 1'b1;
          gnt_idx[q]    = noc_pkg::port_idx_t'(idx);
        end
      end
    end
  end

  // ----------------------------------------
  // Pointer update
  // ----------------------------------------
  always_ff @(posedge clk) begin
    if (!reset_n) begin
      for (int q = 0; q < noc_pkg::N_PORTS; q++) begin
        rr_ptr[q] <= noc_pkg::port_idx_t'(noc_pkg::PORT_CORE);
      end
    end else begin
      for (int q = 0; q < noc_pkg::N_PORTS; q++) begin
        if (|grant[q]) begin
          rr_ptr[q] <= idx_inc(gnt_idx[q]);  // Winner drops to lowest priority
        end
      end
    end
  end

  // ----------------------------------------
  // Crossbar
  // ----------------------------------------
  // Grant rows are one-hot, so a plain select per input is enough
  always_comb begin
    o_data = '0;
    for (int q = 0; q < noc_pkg::N_PORTS; q++) begin
      for (int i = 0; i < noc_pkg::N_PORTS; i++) begin
        if (grant[q][i]) begin
          o_data[q] = i_heads[i];
        end
      end
    end
  end

  // Output valids and queue read strobes
  always_comb begin
    o_data_val = '0;
    o_rd       = '0;
    for (int q = 0; q < noc_pkg::N_PORTS; q++) begin
      o_data_val[q] = |grant[q];           // Any winner means a transfer
      o_rd          = o_rd | grant[q];     // A head leaves on at most one output
    end
  end

endmodule

// ==== verilog/route_calc.sv ====
module route_calc #(
  parameter noc_pkg::coord_t X_LOC = '0,  // Column of this router
  parameter noc_pkg::coord_t Y_LOC = '0   // Row of this router
) (
  input  noc_pkg::packet_t  i_head,      // Head packet of one input queue
  input  logic              i_head_val,  // Head is a real packet
  output noc_pkg::port_vec_t o_req       // One-hot output request
);

  // ----------------------------------------
  // Destination compares
  // ----------------------------------------
  logic x_gt;  // Destination lies east
  logic x_lt;  // Destination lies west
  logic y_gt;  // Destination lies south
  logic y_lt;  // Destination lies north

  assign x_gt = (i_head.x_dest > X_LOC);
  assign x_lt = (i_head.x_dest < X_LOC);
  assign y_gt = (i_head.y_dest > Y_LOC);
  assign y_lt = (i_head.y_dest < Y_LOC);

  // XY order: resolve the column first, then the row
  always_comb begin
    o_req = '0;
    if (i_head_val) begin
      if (x_gt) begin
        o_req[noc_pkg::PORT_EAST] = 1'b1;
      end else if (x_lt) begin
        o_req[noc_pkg::PORT_WEST] = 1'b1;
      end else if (y_gt) begin
        o_req[noc_pkg::PORT_SOUTH] = 1'b1;
      end else if (y_lt) begin
        o_req[noc_pkg::PORT_NORTH] = 1'b1;
      end else begin
        // Packet has arrived, eject to the local core
        o_req[noc_pkg::PORT_CORE] = 1'b1;
      end
    end
  end

endmodule

// ==== verilog/input_queue.sv ====
module input_queue (
  input  logic             clk,
  input  logic             reset_n,
  input  noc_pkg::packet_t i_data,      // From upstream sender
  input  logic             i_data_val,  // Upstream has a packet
  output logic             o_en,        // Room for a packet, registered
  input  logic             i_rd,        // Pop strobe from the output stage
  output noc_pkg::packet_t o_head,      // Oldest packet in the queue
  output logic             o_head_val   // Head holds a real packet
);

  // ----------------------------------------
  // Storage and pointers
  // ----------------------------------------
  noc_pkg::packet_t mem [noc_pkg::QUEUE_DEPTH];  // Circular buffer, no reset

  noc_pkg::qptr_t                   wr_ptr;     // Next free slot
  noc_pkg::qptr_t                   rd_ptr;     // Current head slot
  logic [noc_pkg::QUEUE_PTR_W:0]    count;      // Occupancy, 0 to QUEUE_DEPTH
  logic [noc_pkg::QUEUE_PTR_W:0]    count_nxt;
  logic                             en_q;       // Registered not-full

  logic wr_en;
  logic rd_en;

  // Advance a pointer with wrap at the last slot
  function automatic noc_pkg::qptr_t ptr_inc(input noc_pkg::qptr_t ptr);
    if (ptr == noc_pkg::qptr_t'(noc_pkg::QUEUE_DEPTH - 1)) begin
      return '0;
    end
    return ptr + 1'b1;
  endfunction

  assign wr_en = i_data_val & en_q;        // Valid meets enable
  assign rd_en = i_rd & (count != '0);     // Never pop an empty queue

  // Occupancy after this edge
  always_comb begin
    count_nxt = count;
    case ({wr_en, rd_en})
      2'b10:   count_nxt = count + 1'b1;   // Push only
      2'b01:   count_nxt = count - 1'b1;   // Pop only
      default: count_nxt = count;          // Idle or push with pop
    endcase
  end

  // ----------------------------------------
  // Control state
  // ----------------------------------------
  always_ff @(posedge clk) begin
    if (!reset_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
      en_q   <= 1'b1;                      // Empty queue accepts at once
    end else begin
      if (wr_en) begin
        wr_ptr <= ptr_inc(wr_ptr);
      end
      if (rd_en) begin
        rd_ptr <= ptr_inc(rd_ptr);
      end
      count <= count_nxt;
      // Enable drops the cycle after the last slot fills
      en_q  <= (count_nxt != noc_pkg::QUEUE_DEPTH);
    end
  end

  // Payload write
  always_ff @(posedge clk) begin
    if (wr_en) begin
      mem[wr_ptr] <= i_data;
    end
  end

  // Head of queue, read straight from the buffer
  assign o_head     = mem[rd_ptr];
  assign o_head_val = (count != '0);
  assign o_en       = en_q;

endmodule

// ==== verilog/noc_pkg.sv ====
package noc_pkg;

  // ----------------------------------------
  // Router and mesh dimensions
  // ----------------------------------------
  localparam int N_PORTS = 5;                 // Core plus four mesh links

  // Port indices, shared by inputs and outputs
  localparam int PORT_CORE  = 0;
  localparam int PORT_NORTH = 1;
  localparam int PORT_EAST  = 2;
  localparam int PORT_SOUTH = 3;
  localparam int PORT_WEST  = 4;

  localparam int X_NODES = 4;                 // Mesh columns
  localparam int Y_NODES = 4;                 // Mesh rows

  // One coordinate must cover the larger axis
  localparam int COORD_W = $clog2((X_NODES > Y_NODES) ? X_NODES : Y_NODES);

  localparam int PAYLOAD_W   = 16;            // Data bits carried per packet
  localparam int QUEUE_DEPTH = 4;             // Entries per input queue

  localparam int QUEUE_PTR_W = $clog2(QUEUE_DEPTH);  // Read/write pointer width
  localparam int PORT_W      = $clog2(N_PORTS);      // Width of a port index

  // ----------------------------------------
  // Types
  // ----------------------------------------
  typedef logic [COORD_W-1:0]     coord_t;     // One mesh coordinate
  typedef logic [QUEUE_PTR_W-1:0] qptr_t;      // Queue slot index
  typedef logic [PORT_W-1:0]      port_idx_t;  // Encoded port number

  // Destination first, payload in the low bits
  typedef struct packed {
    coord_t               x_dest;
    coord_t               y_dest;
    logic [PAYLOAD_W-1:0] payload;
  } packet_t;

  typedef logic [0:N_PORTS-1] port_vec_t;      // One bit per port, core first

  // Requests are [input][output], grants are [output][input]
  typedef port_vec_t [0:N_PORTS-1] req_mat_t;

  typedef packet_t [0:N_PORTS-1] packet_bus_t; // One packet per port

endpackage
